//--- hw/rs_m_pkg.sv
/*
 * RV32M unit shared types. Holds the operation encoding and the
 * request and response structs of the pipeline interface.
 */
`default_nettype none

package rs_m_pkg;

    typedef enum logic [3:0] {
        M_NOP    = 4'd0,
        M_MUL    = 4'd1,
        M_MULH   = 4'd2,
        M_MULHSU = 4'd3,
        M_MULHU  = 4'd4,
        M_DIV    = 4'd5,
        M_DIVU   = 4'd6,
        M_REM    = 4'd7,
        M_REMU   = 4'd8
    } m_op_e;

    // one instruction as seen by the execute stage.
    typedef struct packed {
        m_op_e       op;
        logic [31:0] rs1;    // dividend or multiplicand.
        logic [31:0] rs2;
    } m_req_t;

    typedef struct packed {
        logic        hold;   // stall the stage.
        logic [31:0] result;
    } m_rsp_t;

endpackage

`default_nettype wire

//--- hw/mul.sv
/*
 * RV32M multiplier. A single 17x17 signed multiply-accumulate steps
 * through the four 16-bit partial products, low-low first.
 */
`timescale 1ns/1ps
`default_nettype none

module mul (
    input  logic            clk,
    input  logic            reset,
    input  logic [31:0]     first_operand_i,
    input  logic [31:0]     second_operand_i,
    input  rs_m_pkg::m_op_e op_i,
    output logic            hold_o,
    output logic [31:0]     result_o
);

    typedef enum logic [1:0] {
        ST_LL,
        ST_LH,
        ST_HL,
        ST_HH
    } state_e;

    state_e             state_q;
    state_e             state_d;
    logic [1:0]         sign_mode;   // bit 0 first operand, bit 1 second.
    logic               is_mul_op;
    logic               low_only;
    logic [15:0]        half_a;
    logic [15:0]        half_b;
    logic               ext_a;
    logic               ext_b;
    logic signed [16:0] mul_a;
    logic signed [16:0] mul_b;
    logic signed [33:0] product;
    logic [34:0]        acc_in;
    logic [34:0]        mac;
    logic [34:0]        acc_d;
    logic [34:0]        acc_q;

    always_comb begin
        case (op_i)
            rs_m_pkg::M_MULH:   sign_mode = 2'b11;
            rs_m_pkg::M_MULHSU: sign_mode = 2'b01;
            default:            sign_mode = 2'b00;
        endcase
    end

    assign is_mul_op = op_i inside {rs_m_pkg::M_MUL, rs_m_pkg::M_MULH,
                                    rs_m_pkg::M_MULHSU, rs_m_pkg::M_MULHU};
    assign low_only  = (op_i == rs_m_pkg::M_MUL);

    assign mul_a   = {ext_a, half_a};
    assign mul_b   = {ext_b, half_b};
    assign product = mul_a * mul_b;
    assign mac     = {product[33], product} + acc_in;

    always_comb begin
        state_d = state_q;
        hold_o  = 1'b0;
        half_a  = first_operand_i[15:0];
        half_b  = second_operand_i[15:0];
        ext_a   = 1'b0;
        ext_b   = 1'b0;
        acc_in  = acc_q;
        acc_d   = mac;

        case (state_q)
            ST_LL: begin
                acc_in = '0;   // low halves are always unsigned.
                if (is_mul_op) begin
                    hold_o  = 1'b1;
                    state_d = ST_LH;
                end
            end
            ST_LH: begin
                half_b = second_operand_i[31:16];
                ext_b  = sign_mode[1] & second_operand_i[31];
                acc_in = {19'b0, acc_q[31:16]};
                if (low_only) begin
                    acc_d = {3'b0, mac[15:0], acc_q[15:0]};   // keep the finished low half.
                end
                hold_o  = 1'b1;
                state_d = ST_HL;
            end
            ST_HL: begin
                half_a = first_operand_i[31:16];
                ext_a  = sign_mode[0] & first_operand_i[31];
                if (low_only) begin
                    // MUL is complete after this step.
                    acc_in  = {19'b0, acc_q[31:16]};
                    acc_d   = {3'b0, mac[15:0], acc_q[15:0]};
                    state_d = ST_LL;
                end else begin
                    hold_o  = 1'b1;
                    state_d = ST_HH;
                end
            end
            ST_HH: begin
                half_a  = first_operand_i[31:16];
                half_b  = second_operand_i[31:16];
                ext_a   = sign_mode[0] & first_operand_i[31];
                ext_b   = sign_mode[1] & second_operand_i[31];
                acc_in  = {{16{acc_q[34]}}, acc_q[34:16]};   // arithmetic shift by 16.
                state_d = ST_LL;
            end
            default: begin
                state_d = ST_LL;
            end
        endcase
    end

    assign result_o = acc_d[31:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ST_LL;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        acc_q <= acc_d;
    end

    // the later steps reuse the op to pick sign extension.
    a_op_stable: assert property (@(posedge clk) disable iff (reset)
        hold_o |=> $stable(op_i))
        else $error("mul: op changed while hold was high");

endmodule

`default_nettype wire

//--- hw/div.sv
/*
 * RV32M divider. Restoring division, one quotient bit per cycle, with
 * the RISC-V results for division by zero and signed overflow.
 */
`timescale 1ns/1ps
`default_nettype none

module div (
    input  logic            clk,
    input  logic            reset,
    input  logic [31:0]     dividend_i,
    input  logic [31:0]     divisor_i,
    input  rs_m_pkg::m_op_e op_i,
    output logic            hold_o,
    output logic [31:0]     result_o
);

    typedef enum logic [1:0] {
        IDLE,
        CALC,
        DONE
    } state_e;

    state_e      state_q;
    state_e      state_d;
    logic        is_div_op;
    logic        is_signed;
    logic        is_rem;
    logic        div_zero;
    logic        overflow;
    logic        start;
    logic [31:0] mag_dividend;
    logic [31:0] mag_divisor;
    logic [31:0] quo_q;
    logic [31:0] rem_q;
    logic [31:0] dvs_q;
    logic [4:0]  count_q;
    logic        neg_quo_q;
    logic        neg_rem_q;
    logic [32:0] shifted;
    logic [33:0] diff;
    logic [31:0] quo_fix;
    logic [31:0] rem_fix;

    assign is_div_op = op_i inside {rs_m_pkg::M_DIV, rs_m_pkg::M_DIVU,
                                    rs_m_pkg::M_REM, rs_m_pkg::M_REMU};
    assign is_signed = op_i inside {rs_m_pkg::M_DIV, rs_m_pkg::M_REM};
    assign is_rem    = op_i inside {rs_m_pkg::M_REM, rs_m_pkg::M_REMU};

    assign div_zero = (divisor_i == 32'd0);
    assign overflow = is_signed && (dividend_i == 32'h8000_0000) && (divisor_i == 32'hffff_ffff);
    assign start    = (state_q == IDLE) && is_div_op && !div_zero && !overflow;

    // -2^31 maps to 2^31, which still fits unsigned.
    assign mag_dividend = (is_signed && dividend_i[31]) ? -dividend_i : dividend_i;
    assign mag_divisor  = (is_signed && divisor_i[31]) ? -divisor_i : divisor_i;

    assign shifted = {rem_q, quo_q[31]};
    assign diff    = {1'b0, shifted} - {2'b0, dvs_q};   // bit 33 is the borrow.

    assign quo_fix = neg_quo_q ? -quo_q : quo_q;
    assign rem_fix = neg_rem_q ? -rem_q : rem_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start) begin
                    state_d = CALC;
                end
            end
            CALC: begin
                if (count_q == 5'd31) begin
                    state_d = DONE;
                end
            end
            default: begin
                state_d = IDLE;   // DONE lasts one cycle.
            end
        endcase
    end

    always_comb begin
        hold_o   = 1'b0;
        result_o = '0;
        case (state_q)
            IDLE: begin
                hold_o = start;
                if (is_div_op && div_zero) begin
                    result_o = is_rem ? dividend_i : 32'hffff_ffff;
                end else if (is_div_op && overflow) begin
                    result_o = is_rem ? 32'd0 : dividend_i;
                end
            end
            CALC: hold_o = 1'b1;
            DONE: result_o = is_rem ? rem_fix : quo_fix;
            default: hold_o = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
            count_q <= '0;
        end else begin
            state_q <= state_d;
            count_q <= (state_q == CALC) ? count_q + 5'd1 : 5'd0;
        end
    end

    // quotient shifts in from the bottom while the dividend shifts out the top.
    always_ff @(posedge clk) begin
        if (start) begin
            quo_q     <= mag_dividend;
            rem_q     <= '0;
            dvs_q     <= mag_divisor;
            neg_quo_q <= is_signed & (dividend_i[31] ^ divisor_i[31]);
            neg_rem_q <= is_signed & dividend_i[31];
        end else if (state_q == CALC) begin
            quo_q <= {quo_q[30:0], ~diff[33]};
            rem_q <= diff[33] ? shifted[31:0] : diff[31:0];
        end
    end

    a_hold_bounded: assert property (@(posedge clk) disable iff (reset)
        $rose(hold_o) |-> ##33 !hold_o)
        else $error("div: hold not released after 33 cycles");

    a_op_stable: assert property (@(posedge clk) disable iff (reset)
        (state_q != IDLE) |-> $stable(op_i))
        else $error("div: op changed during a divide");

endmodule

`default_nettype wire

//--- hw/m_unit.sv
/*
 * RV32M execute unit. Runs the multiplier and divider side by side,
 * picks the result by op group and merges their stall requests.
 */
`timescale 1ns/1ps
`default_nettype none

module m_unit (
    input  logic             clk,
    input  logic             reset,
    input  rs_m_pkg::m_req_t req_i,
    output rs_m_pkg::m_rsp_t rsp_o
);

    rs_m_pkg::m_op_e op;
    logic [31:0]     rs1;
    logic [31:0]     rs2;
    logic            mul_hold;
    logic            div_hold;
    logic [31:0]     mul_result;
    logic [31:0]     div_result;

    assign op  = req_i.op;
    assign rs1 = req_i.rs1;
    assign rs2 = req_i.rs2;

    // each engine ignores ops outside its own group.
    mul u_mul (
        .clk              (clk),
        .reset            (reset),
        .first_operand_i  (rs1),
        .second_operand_i (rs2),
        .op_i             (op),
        .hold_o           (mul_hold),
        .result_o         (mul_result)
    );

    div u_div (
        .clk        (clk),
        .reset      (reset),
        .dividend_i (rs1),
        .divisor_i  (rs2),
        .op_i       (op),
        .hold_o     (div_hold),
        .result_o   (div_result)
    );

    always_comb begin
        rsp_o.hold = mul_hold | div_hold;
        case (op)
            rs_m_pkg::M_MUL, rs_m_pkg::M_MULH,
            rs_m_pkg::M_MULHSU, rs_m_pkg::M_MULHU: begin
                rsp_o.result = mul_result;
            end
            rs_m_pkg::M_DIV, rs_m_pkg::M_DIVU,
            rs_m_pkg::M_REM, rs_m_pkg::M_REMU: begin
                rsp_o.result = div_result;
            end
            default: begin
                rsp_o.result = '0;   // nop.
            end
        endcase
    end

    // only one instruction sits in the stage.
    a_one_engine: assert property (@(posedge clk) disable iff (reset)
        !(mul_hold && div_hold))
        else $error("m_unit: multiplier and divider both holding");

endmodule

`default_nettype wire

//--- dv/tb_m_unit.sv
/*
 * Testbench for the RV32M execute unit. Sends random and corner requests
 * from a fixed seed and checks results and stall lengths against a model.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_m_unit;

    localparam int NUM_REQ        = 400;
    localparam int NUM_DIRECTED   = 9;
    localparam int TIMEOUT_CYCLES = NUM_REQ * 40 + 100;

    logic             clk;
    logic             reset;
    rs_m_pkg::m_req_t req;
    rs_m_pkg::m_rsp_t rsp;
    integer           seed;
    int               errors;
    int               cycle_count = 0;

    m_unit u_dut (
        .clk   (clk),
        .reset (reset),
        .req_i (req),
        .rsp_o (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles before all requests finished", cycle_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // RISC-V M rules on 64-bit values, with the expected stall length.
    task automatic model(input rs_m_pkg::m_op_e op, input logic [31:0] a,
                         input logic [31:0] b, output logic [31:0] res, output int hold);
        longint      sa;
        longint      sb;
        longint      q;
        logic [63:0] prod;
        sa   = {{32{a[31]}}, a};
        sb   = {{32{b[31]}}, b};
        res  = 32'd0;
        hold = 0;
        case (op)
            rs_m_pkg::M_MUL: begin
                prod = sa * sb;
                res  = prod[31:0];
                hold = 2;
            end
            rs_m_pkg::M_MULH, rs_m_pkg::M_MULHSU, rs_m_pkg::M_MULHU: begin
                if (op == rs_m_pkg::M_MULH) prod = sa * sb;
                else if (op == rs_m_pkg::M_MULHSU) prod = sa * {32'b0, b};
                else prod = {32'b0, a} * {32'b0, b};
                res  = prod[63:32];
                hold = 3;
            end
            rs_m_pkg::M_DIV, rs_m_pkg::M_REM: begin
                if (b == 32'd0) begin
                    res = (op == rs_m_pkg::M_DIV) ? 32'hffff_ffff : a;
                end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
                    res = (op == rs_m_pkg::M_DIV) ? a : 32'd0;
                end else begin
                    q    = (op == rs_m_pkg::M_DIV) ? sa / sb : sa % sb;   // truncates toward zero.
                    res  = q[31:0];
                    hold = 33;
                end
            end
            rs_m_pkg::M_DIVU, rs_m_pkg::M_REMU: begin
                if (b == 32'd0) begin
                    res = (op == rs_m_pkg::M_DIVU) ? 32'hffff_ffff : a;
                end else begin
                    res  = (op == rs_m_pkg::M_DIVU) ? a / b : a % b;
                    hold = 33;
                end
            end
            default: res = 32'd0;
        endcase
    endtask

    // one in four operands comes from the corner values.
    task automatic draw_operand(output logic [31:0] v);
        logic [31:0] r;
        logic [31:0] c;
        r = $random(seed);
        c = $random(seed);
        if (r[1:0] == 2'b00) begin
            case (c % 32'd5)
                32'd0:   v = 32'd0;
                32'd1:   v = 32'd1;
                32'd2:   v = 32'hffff_ffff;
                32'd3:   v = 32'h7fff_ffff;
                default: v = 32'h8000_0000;
            endcase
        end else begin
            v = $random(seed);
        end
    endtask

    task automatic directed_request(input int idx, output rs_m_pkg::m_req_t r);
        case (idx)
            0: r = '{op: rs_m_pkg::M_MULH, rs1: 32'h8000_0000, rs2: 32'h8000_0000};
            1: r = '{op: rs_m_pkg::M_MULHSU, rs1: 32'hffff_ffff, rs2: 32'hffff_ffff};
            2: r = '{op: rs_m_pkg::M_MULHSU, rs1: 32'h8000_0000, rs2: 32'h7fff_ffff};
            3: r = '{op: rs_m_pkg::M_DIV, rs1: 32'h1234_5678, rs2: 32'd0};
            4: r = '{op: rs_m_pkg::M_REMU, rs1: 32'hdead_beef, rs2: 32'd0};
            5: r = '{op: rs_m_pkg::M_DIV, rs1: 32'h8000_0000, rs2: 32'hffff_ffff};
            6: r = '{op: rs_m_pkg::M_REM, rs1: 32'h8000_0000, rs2: 32'hffff_ffff};
            default: r = '{op: rs_m_pkg::M_DIV, rs1: 32'hffff_fff9, rs2: 32'd2};
        endcase
    endtask

    // drive one request and wait for the cycle with hold low.
    task automatic run_request(input rs_m_pkg::m_req_t r);
        rs_m_pkg::m_op_e op;
        logic [31:0]     exp_res;
        int              exp_hold;
        int              hold_cnt;
        op = r.op;
        model(op, r.rs1, r.rs2, exp_res, exp_hold);
        hold_cnt = 0;
        @(posedge clk);
        req <= r;
        @(negedge clk);
        while (rsp.hold) begin
            hold_cnt++;
            @(negedge clk);
        end
        assert (rsp.result == exp_res) else begin
            errors++;
            $display("[ERROR] %0t: %s rs1=%h rs2=%h gave %h, expected %h",
                     $time, op.name(), r.rs1, r.rs2, rsp.result, exp_res);
        end
        assert (hold_cnt == exp_hold) else begin
            errors++;
            $display("[ERROR] %0t: %s rs1=%h rs2=%h held %0d cycles, expected %0d",
                     $time, op.name(), r.rs1, r.rs2, hold_cnt, exp_hold);
        end
    endtask

    initial begin
        rs_m_pkg::m_req_t r;
        rs_m_pkg::m_req_t prev;
        logic [31:0]      pick;
        seed   = 32'h65c2;
        errors = 0;
        reset  = 1'b1;
        req    = '0;
        prev   = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (!rsp.hold && rsp.result == 32'd0) else begin
            errors++;
            $display("[ERROR] %0t: idle after reset shows hold=%b result=%h",
                     $time, rsp.hold, rsp.result);
        end
        for (int i = 0; i < NUM_REQ; i++) begin
            pick = $random(seed);
            if (i < NUM_DIRECTED) begin
                directed_request(i, r);
            end else if (pick[2:0] == 3'd0) begin
                r = prev;   // back-to-back repeat.
            end else begin
                r.op = rs_m_pkg::m_op_e'(4'(pick[31:3] % 29'd9));
                draw_operand(r.rs1);
                draw_operand(r.rs2);
            end
            run_request(r);
            prev = r;
        end
        @(posedge clk);
        $display("%0d requests checked, %0d errors", NUM_REQ, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hw/rs_m_pkg.sv
hw/mul.sv
hw/div.sv
hw/m_unit.sv
dv/tb_m_unit.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_m_unit
FILE_LIST = list.f
OBJ_DIR   = obj_dir
PASS_MSG  = SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
